// ==== logic/can_bus_pkg.sv ====
`default_nettype none

package can_bus_pkg;

    // per-bit strobes from the bit timing logic
    typedef struct packed {
        logic sample;
        logic value;
        logic bit_end;
    } bit_event_t;

    // bus levels
    localparam logic DOMINANT  = 1'b0;
    localparam logic RECESSIVE = 1'b1;

    // CAN CRC-15
    localparam int CRC_WIDTH = 15;
    // x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
    localparam logic [CRC_WIDTH-1:0] CRC_POLY = 15'h4599;

    // equal bits before a complement bit is inserted
    localparam int STUFF_RUN = 5;

endpackage

`default_nettype wire

// ==== logic/can_frame_pkg.sv ====
`default_nettype none

package can_frame_pkg;

    // field widths of the extended identifier layout
    localparam int ADDR_W      = 6;
    localparam int ADDR_HI_W   = 4;
    localparam int ADDR_LO_W   = ADDR_W - ADDR_HI_W;
    localparam int HANDSHAKE_W = 2;
    localparam int ATTR_W      = 2;
    localparam int EXPAND_W    = 4;
    localparam int SIGN_W      = 8;
    localparam int RESERVED_W  = 2;
    localparam int DLC_W       = 4;
    localparam int DATA_W      = 64;
    localparam int EOF_W       = 7;

    // recessive bits needed after an aborted frame before a new SOF
    localparam int IDLE_BITS   = 11;

    // fields in bus order
    typedef enum logic [4:0] {
        IDLE, SOF,
        MSG_TYPE, ADDR_LOCAL, ADDR_REMOTE_HI, SRR, IDE, ADDR_REMOTE_LO,
        HANDSHAKE, ATTRIBUTE, EXPAND_COUNT, CMD_DATA_SIGN,
        RTR, RESERVED, DLC, DATA,
        CRC, CRC_DELIM, ACK_SLOT, ACK_DELIM, EOF
    } rx_state_e;

    typedef struct packed {
        logic                   msg_type;
        logic [ADDR_W-1:0]      local_addr;
        logic [ADDR_W-1:0]      remote_addr;
        logic [HANDSHAKE_W-1:0] handshake;
        logic [ATTR_W-1:0]      attribute;
        logic [EXPAND_W-1:0]    expand_count;
        logic [SIGN_W-1:0]      cmd_data_sign;
        logic [DLC_W-1:0]       dlc;
        logic [DATA_W-1:0]      data;
        // received CRC matched the computed one
        logic                   crc_ok;
        // delimiters and EOF were all recessive
        logic                   form_ok;
    } rx_frame_t;

endpackage

`default_nettype wire

// ==== logic/can_bit_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_bit_timing import can_bus_pkg::*; #(
    parameter int QUANTS_PER_BIT = 10
) (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire        rx_i,
    output bit_event_t evt_o
);

    localparam int CNT_W     = (QUANTS_PER_BIT > 2) ? $clog2(QUANTS_PER_BIT) : 1;
    localparam int SAMPLE_PT = QUANTS_PER_BIT / 2;

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             fall;
    logic [CNT_W-1:0] quant_cnt;

    // two-flop synchroniser, bus idles recessive
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rx_meta <= RECESSIVE;
            rx_sync <= RECESSIVE;
            rx_prev <= RECESSIVE;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // recessive to dominant edge
    assign fall = rx_prev & ~rx_sync;

    // quantum counter, hard resync on every falling edge
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            quant_cnt <= '0;
        end else if (fall || quant_cnt == CNT_W'(QUANTS_PER_BIT - 1)) begin
            quant_cnt <= '0;
        end else begin
            quant_cnt <= quant_cnt + 1'b1;
        end
    end

    // no sample in the edge cycle itself, that level belongs to the new bit
    assign evt_o = '{sample:  (quant_cnt == CNT_W'(SAMPLE_PT)) && !fall,
                     value:   rx_sync,
                     bit_end: (quant_cnt == CNT_W'(QUANTS_PER_BIT - 1))};

endmodule

`default_nettype wire

// ==== logic/can_destuff.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_destuff import can_bus_pkg::*; (
    input  wire             clk_i,
    input  wire             rst_i,
    input  wire bit_event_t evt_i,
    input  wire             stuff_en_i,
    output bit_event_t      evt_o,
    output logic            stuff_err_o
);

    logic       stuff_en_d;
    logic       tail;
    logic       last_val;
    logic       in_stuff;
    logic [2:0] run_cnt;
    logic       active;
    logic       at_limit;

    // one extra bit after the CRC field may still be a stuff bit
    assign active   = stuff_en_i | tail;
    assign at_limit = active && (run_cnt == 3'(STUFF_RUN));

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            stuff_en_d  <= 1'b0;
            tail        <= 1'b0;
            last_val    <= RECESSIVE;
            in_stuff    <= 1'b0;
            run_cnt     <= '0;
            evt_o       <= '0;
            stuff_err_o <= 1'b0;
        end else begin
            stuff_en_d    <= stuff_en_i;
            stuff_err_o   <= 1'b0;
            evt_o.sample  <= 1'b0;
            evt_o.value   <= evt_i.value;
            evt_o.bit_end <= evt_i.bit_end & ~in_stuff;
            // new run starts with the SOF bit already counted
            if (stuff_en_i && !stuff_en_d) begin
                run_cnt <= 3'd1;
            end
            if (stuff_en_d && !stuff_en_i) begin
                tail <= 1'b1;
            end
            if (evt_i.sample) begin
                last_val <= evt_i.value;
                tail     <= 1'b0;
                in_stuff <= at_limit;
                if (at_limit) begin
                    // stuff bit itself opens the next run
                    run_cnt     <= 3'd1;
                    stuff_err_o <= (evt_i.value == last_val);
                end else begin
                    evt_o.sample <= 1'b1;
                    if (active && evt_i.value == last_val) begin
                        run_cnt <= run_cnt + 3'd1;
                    end else begin
                        run_cnt <= 3'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/can_crc15.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_crc15 import can_bus_pkg::*; (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire bit_event_t      evt_i,
    input  wire                  en_i,
    input  wire                  clr_i,
    output logic [CRC_WIDTH-1:0] crc_o
);

    logic feedback;

    assign feedback = evt_i.value ^ crc_o[CRC_WIDTH-1];

    // serial LFSR, one step per destuffed bit
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            crc_o <= '0;
        end else if (clr_i) begin
            crc_o <= '0;
        end else if (en_i && evt_i.sample) begin
            crc_o <= {crc_o[CRC_WIDTH-2:0], 1'b0} ^ ({CRC_WIDTH{feedback}} & CRC_POLY);
        end
    end

endmodule

`default_nettype wire

// ==== logic/can_rx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_fsm import can_bus_pkg::*; import can_frame_pkg::*; (
    input  wire             clk_i,
    input  wire             rst_i,
    input  wire bit_event_t evt_i,
    input  wire             stuff_err_i,
    output rx_state_e       state_o,
    output logic [6:0]      field_bit_o,
    output logic            stuff_en_o,
    output logic            crc_en_o,
    output logic            crc_clr_o,
    output logic            frame_done_o
);

    logic [3:0] idle_cnt;
    logic       bus_idle;
    logic       last_bit;

    // length of each field in bits
    function automatic logic [6:0] field_len(input rx_state_e st);
        case (st)
            ADDR_LOCAL:     field_len = 7'(ADDR_W);
            ADDR_REMOTE_HI: field_len = 7'(ADDR_HI_W);
            ADDR_REMOTE_LO: field_len = 7'(ADDR_LO_W);
            HANDSHAKE:      field_len = 7'(HANDSHAKE_W);
            ATTRIBUTE:      field_len = 7'(ATTR_W);
            EXPAND_COUNT:   field_len = 7'(EXPAND_W);
            CMD_DATA_SIGN:  field_len = 7'(SIGN_W);
            RESERVED:       field_len = 7'(RESERVED_W);
            DLC:            field_len = 7'(DLC_W);
            DATA:           field_len = 7'(DATA_W);
            CRC:            field_len = 7'(CRC_WIDTH);
            EOF:            field_len = 7'(EOF_W);
            default:        field_len = 7'd1;
        endcase
    endfunction

    // field order on the bus
    function automatic rx_state_e next_field(input rx_state_e st);
        case (st)
            SOF:            next_field = MSG_TYPE;
            MSG_TYPE:       next_field = ADDR_LOCAL;
            ADDR_LOCAL:     next_field = ADDR_REMOTE_HI;
            ADDR_REMOTE_HI: next_field = SRR;
            SRR:            next_field = IDE;
            IDE:            next_field = ADDR_REMOTE_LO;
            ADDR_REMOTE_LO: next_field = HANDSHAKE;
            HANDSHAKE:      next_field = ATTRIBUTE;
            ATTRIBUTE:      next_field = EXPAND_COUNT;
            EXPAND_COUNT:   next_field = CMD_DATA_SIGN;
            CMD_DATA_SIGN:  next_field = RTR;
            RTR:            next_field = RESERVED;
            RESERVED:       next_field = DLC;
            DLC:            next_field = DATA;
            DATA:           next_field = CRC;
            CRC:            next_field = CRC_DELIM;
            CRC_DELIM:      next_field = ACK_SLOT;
            ACK_SLOT:       next_field = ACK_DELIM;
            ACK_DELIM:      next_field = EOF;
            default:        next_field = IDLE;
        endcase
    endfunction

    assign last_bit = (field_bit_o == field_len(state_o) - 7'd1);
    assign bus_idle = (idle_cnt == 4'(IDLE_BITS));

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_o      <= IDLE;
            field_bit_o  <= '0;
            idle_cnt     <= 4'(IDLE_BITS);
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            if (stuff_err_i) begin
                // abort and wait for bus idle before the next SOF
                state_o     <= IDLE;
                field_bit_o <= '0;
                idle_cnt    <= '0;
            end else if (state_o == IDLE) begin
                if (evt_i.sample) begin
                    if (evt_i.value == DOMINANT && bus_idle) begin
                        state_o <= SOF;
                    end else if (evt_i.value == DOMINANT) begin
                        idle_cnt <= '0;
                    end else if (!bus_idle) begin
                        idle_cnt <= idle_cnt + 4'd1;
                    end
                end
            end else if (state_o == SOF) begin
                // SOF was sampled in IDLE, hold until that bit ends
                if (evt_i.bit_end) begin
                    state_o <= next_field(state_o);
                end
            end else if (evt_i.sample) begin
                if (last_bit) begin
                    state_o      <= next_field(state_o);
                    field_bit_o  <= '0;
                    frame_done_o <= (state_o == EOF);
                end else begin
                    field_bit_o <= field_bit_o + 7'd1;
                end
            end
        end
    end

    assign stuff_en_o = (state_o >= SOF) && (state_o <= CRC);
    assign crc_en_o   = (state_o >= SOF) && (state_o <= DATA);
    assign crc_clr_o  = (state_o == IDLE);

endmodule

`default_nettype wire

// ==== logic/can_field_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_field_capture import can_bus_pkg::*; import can_frame_pkg::*; (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire bit_event_t      evt_i,
    input  wire rx_state_e       state_i,
    input  wire [6:0]            field_bit_i,
    input  wire [CRC_WIDTH-1:0]  crc_i,
    input  wire                  frame_done_i,
    output rx_frame_t            frame_o,
    output logic                 frame_valid_o
);

    logic [CRC_WIDTH-2:0] crc_rx;
    logic [CRC_WIDTH-1:0] crc_next;
    logic                 bit_in;

    assign bit_in   = evt_i.value;
    assign crc_next = {crc_rx, bit_in};

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= frame_done_i;
        end
    end

    // fields shift in msb first
    always_ff @(posedge clk_i) begin
        if (state_i == SOF) begin
            frame_o.crc_ok  <= 1'b0;
            frame_o.form_ok <= 1'b1;
        end
        if (evt_i.sample) begin
            case (state_i)
                MSG_TYPE:       frame_o.msg_type <= bit_in;
                ADDR_LOCAL:     frame_o.local_addr <= {frame_o.local_addr[ADDR_W-2:0], bit_in};
                // remote address is split around SRR and IDE
                ADDR_REMOTE_HI,
                ADDR_REMOTE_LO: frame_o.remote_addr <= {frame_o.remote_addr[ADDR_W-2:0], bit_in};
                HANDSHAKE:      frame_o.handshake <= {frame_o.handshake[HANDSHAKE_W-2:0], bit_in};
                ATTRIBUTE:      frame_o.attribute <= {frame_o.attribute[ATTR_W-2:0], bit_in};
                EXPAND_COUNT:   frame_o.expand_count <=
                                    {frame_o.expand_count[EXPAND_W-2:0], bit_in};
                CMD_DATA_SIGN:  frame_o.cmd_data_sign <=
                                    {frame_o.cmd_data_sign[SIGN_W-2:0], bit_in};
                DLC:            frame_o.dlc <= {frame_o.dlc[DLC_W-2:0], bit_in};
                DATA:           frame_o.data <= {frame_o.data[DATA_W-2:0], bit_in};
                CRC: begin
                    crc_rx <= crc_next[CRC_WIDTH-2:0];
                    if (field_bit_i == 7'(CRC_WIDTH - 1)) begin
                        frame_o.crc_ok <= (crc_next == crc_i);
                    end
                end
                CRC_DELIM, ACK_DELIM, EOF: begin
                    if (bit_in == DOMINANT) begin
                        frame_o.form_ok <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/can_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_top import can_bus_pkg::*; import can_frame_pkg::*; #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int BIT_RATE = 5_000_000
) (
    input  wire       clk_i,
    input  wire       rst_i,
    input  wire       rx_i,
    output rx_frame_t frame_o,
    output logic      frame_valid_o,
    output logic      stuff_err_o
);

    localparam int QUANTS_PER_BIT = CLK_FREQ / BIT_RATE;

    bit_event_t           raw_evt;
    bit_event_t           data_evt;
    logic                 stuff_err;
    rx_state_e            state;
    logic [6:0]           field_bit;
    logic                 stuff_en;
    logic                 crc_en;
    logic                 crc_clr;
    logic                 frame_done;
    logic [CRC_WIDTH-1:0] crc;

    can_bit_timing #(.QUANTS_PER_BIT(QUANTS_PER_BIT)) can_bit_timing_i (
        .clk_i(clk_i), .rst_i(rst_i), .rx_i(rx_i), .evt_o(raw_evt)
    );

    can_destuff can_destuff_i (
        .clk_i(clk_i), .rst_i(rst_i), .evt_i(raw_evt), .stuff_en_i(stuff_en),
        .evt_o(data_evt), .stuff_err_o(stuff_err)
    );

    can_crc15 can_crc15_i (
        .clk_i(clk_i), .rst_i(rst_i), .evt_i(data_evt), .en_i(crc_en),
        .clr_i(crc_clr), .crc_o(crc)
    );

    can_rx_fsm can_rx_fsm_i (
        .clk_i(clk_i), .rst_i(rst_i), .evt_i(data_evt), .stuff_err_i(stuff_err),
        .state_o(state), .field_bit_o(field_bit), .stuff_en_o(stuff_en),
        .crc_en_o(crc_en), .crc_clr_o(crc_clr), .frame_done_o(frame_done)
    );

    can_field_capture can_field_capture_i (
        .clk_i(clk_i), .rst_i(rst_i), .evt_i(data_evt), .state_i(state),
        .field_bit_i(field_bit), .crc_i(crc), .frame_done_i(frame_done),
        .frame_o(frame_o), .frame_valid_o(frame_valid_o)
    );

    assign stuff_err_o = stuff_err;

endmodule

`default_nettype wire

// ==== verification/can_rx_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_assert import can_frame_pkg::*; (
    input wire            clk_i,
    input wire            rst_i,
    input wire rx_state_e state_i,
    input wire rx_frame_t frame_i,
    input wire            frame_valid_i,
    input wire            stuff_err_i
);

    logic started;
    logic aborted;
    logic have_frame;
    int   n_quiet;
    int   n_pulse;
    int   n_abort;
    int   n_no_frame;
    int   n_hold;
    int   fail_cnt;

    assign fail_cnt = n_quiet + n_pulse + n_abort + n_no_frame + n_hold;

    // aborted stays set from a stuff error until the next SOF
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            started    <= 1'b0;
            aborted    <= 1'b0;
            have_frame <= 1'b0;
        end else begin
            if (state_i == SOF) begin
                started <= 1'b1;
                aborted <= 1'b0;
            end
            if (stuff_err_i) begin
                aborted <= 1'b1;
            end
            if (frame_valid_i) begin
                have_frame <= 1'b1;
            end
        end
    end

    a_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !started |-> !frame_valid_i && !stuff_err_i) else begin
        n_quiet++;
        $error("frame_valid_o or stuff_err_o before the first SOF");
    end

    a_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        frame_valid_i |=> !frame_valid_i) else begin
        n_pulse++;
        $error("frame_valid_o longer than one cycle");
    end

    a_abort: assert property (@(posedge clk_i) disable iff (rst_i)
        stuff_err_i |=> !stuff_err_i && state_i == IDLE) else begin
        n_abort++;
        $error("stuff error did not return the FSM to IDLE in one pulse");
    end

    a_no_frame: assert property (@(posedge clk_i) disable iff (rst_i)
        aborted |-> !frame_valid_i) else begin
        n_no_frame++;
        $error("frame_valid_o after a stuff error");
    end

    // received frame holds while the bus is idle
    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        have_frame && $past(state_i) == IDLE |-> $stable(frame_i)) else begin
        n_hold++;
        $error("frame_o changed while idle");
    end

endmodule

bind can_rx_top can_rx_assert can_rx_assert_i (
    .clk_i(clk_i), .rst_i(rst_i), .state_i(state), .frame_i(frame_o),
    .frame_valid_i(frame_valid_o), .stuff_err_i(stuff_err_o)
);

`default_nettype wire

// ==== verification/can_tx_tasks.svh ====
// serial frame generator, one bus bit every QUANTS_PER_BIT clocks on rx_i

logic tx_bits[$];

// queue a field msb first
task automatic push_field(input logic [63:0] val, input int width);
    for (int i = width - 1; i >= 0; i--) begin
        tx_bits.push_back(val[i]);
    end
endtask

// CAN CRC-15 over the queued bits, SOF included
function automatic logic [14:0] frame_crc();
    logic [14:0] crc;
    logic        fb;
    crc = '0;
    foreach (tx_bits[i]) begin
        fb  = tx_bits[i] ^ crc[14];
        crc = {crc[13:0], 1'b0};
        if (fb) begin
            // x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
            crc = crc ^ 15'h4599;
        end
    end
    return crc;
endfunction

task automatic drive_bit(input logic level);
    rx_i = level;
    repeat (QUANTS_PER_BIT) @(negedge clk_i);
endtask

task automatic idle_bits(input int n);
    repeat (n) drive_bit(1'b1);
endtask

// SOF through CRC with stuff bits, then delimiters and EOF
task automatic send_frame(input rx_frame_t f, input logic crc_flip, input logic delim_bad);
    logic [14:0] crc;
    logic        last;
    int          run;
    tx_bits.delete();
    push_field(64'd0, 1);
    push_field(64'(f.msg_type), 1);
    push_field(64'(f.local_addr), ADDR_W);
    push_field(64'(f.remote_addr[ADDR_W-1:ADDR_LO_W]), ADDR_HI_W);
    // SRR and IDE
    push_field(64'd3, 2);
    push_field(64'(f.remote_addr[ADDR_LO_W-1:0]), ADDR_LO_W);
    push_field(64'(f.handshake), HANDSHAKE_W);
    push_field(64'(f.attribute), ATTR_W);
    push_field(64'(f.expand_count), EXPAND_W);
    push_field(64'(f.cmd_data_sign), SIGN_W);
    // RTR, r1, r0
    push_field(64'd0, 3);
    push_field(64'(f.dlc), DLC_W);
    push_field(f.data, DATA_W);
    crc    = frame_crc();
    crc[0] = crc[0] ^ crc_flip;
    push_field(64'(crc), 15);
    last = 1'b1;
    run  = 0;
    foreach (tx_bits[i]) begin
        drive_bit(tx_bits[i]);
        run  = (tx_bits[i] == last) ? run + 1 : 1;
        last = tx_bits[i];
        if (run == 5) begin
            drive_bit(~last);
            last = ~last;
            run  = 1;
        end
    end
    drive_bit(~delim_bad);
    // ACK slot left recessive, nobody acknowledges
    drive_bit(1'b1);
    drive_bit(1'b1);
    repeat (7) drive_bit(1'b1);
endtask

// SOF and seven more dominant bits, no stuff bit where one is due
task automatic send_stuff_violation();
    repeat (8) drive_bit(1'b0);
endtask

// ==== verification/tb_can_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_can_rx import can_frame_pkg::*; ();

    localparam int CLK_FREQ       = 50_000_000;
    localparam int BIT_RATE       = 5_000_000;
    localparam int QUANTS_PER_BIT = CLK_FREQ / BIT_RATE;
    localparam int NUM_FRAMES     = 9;
    // 160 bit times per frame at 20 ns per quantum plus a margin
    localparam int WATCHDOG_NS    = (NUM_FRAMES * 160 + 200) * QUANTS_PER_BIT * 20;

    logic      clk_i;
    logic      rst_i;
    logic      rx_i;
    rx_frame_t frame_o;
    logic      frame_valid_o;
    logic      stuff_err_o;
    rx_frame_t exp_frame;
    int        valid_cnt;
    int        err_pulses;
    int        frame_errs;
    int        seq_errs;
    int        frames_sent;

    can_rx_top #(.CLK_FREQ(CLK_FREQ), .BIT_RATE(BIT_RATE)) can_rx_top_i (
        .clk_i(clk_i), .rst_i(rst_i), .rx_i(rx_i),
        .frame_o(frame_o), .frame_valid_o(frame_valid_o), .stuff_err_o(stuff_err_o)
    );

    `include "can_tx_tasks.svh"

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // outputs are settled at the falling edge
    always @(negedge clk_i) begin
        if (frame_valid_o) begin
            valid_cnt++;
            assert (frame_o == exp_frame) else begin
                frame_errs++;
                $display("Fail %0t: frame %0d got %h expected %h",
                         $time, valid_cnt, frame_o, exp_frame);
            end
        end
        if (stuff_err_o) begin
            err_pulses++;
        end
    end

    function automatic rx_frame_t random_frame();
        rx_frame_t f;
        f.msg_type      = 1'($urandom());
        f.local_addr    = ADDR_W'($urandom());
        f.remote_addr   = ADDR_W'($urandom());
        f.handshake     = HANDSHAKE_W'($urandom());
        f.attribute     = ATTR_W'($urandom());
        f.expand_count  = EXPAND_W'($urandom());
        f.cmd_data_sign = SIGN_W'($urandom());
        f.dlc           = DLC_W'($urandom());
        f.data          = {$urandom(), $urandom()};
        f.crc_ok        = 1'b1;
        f.form_ok       = 1'b1;
        return f;
    endfunction

    // wait for frame_valid_o within a few bit times
    task automatic expect_frame(input int want);
        int waited;
        waited = 0;
        while (valid_cnt < want && waited < 4 * QUANTS_PER_BIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (valid_cnt < want) begin
            seq_errs++;
            $display("no frame_valid_o seen for frame %0d", want);
        end
        @(negedge clk_i);
    endtask

    task automatic run_frame(input rx_frame_t f, input logic crc_flip, input logic delim_bad);
        exp_frame         = f;
        exp_frame.crc_ok  = ~crc_flip;
        exp_frame.form_ok = ~delim_bad;
        send_frame(f, crc_flip, delim_bad);
        frames_sent++;
        expect_frame(frames_sent);
        idle_bits(12);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rx_frame_t f;
        rst_i     = 1'b1;
        rx_i      = 1'b1;
        exp_frame = '0;
        void'($urandom(32'hd386));
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        // quiet bus first
        idle_bits(20);
        run_frame(random_frame(), 1'b0, 1'b0);
        run_frame(random_frame(), 1'b0, 1'b0);
        // long runs that force many stuff bits
        f      = random_frame();
        f.data = '0;
        run_frame(f, 1'b0, 1'b0);
        f      = random_frame();
        f.data = '1;
        run_frame(f, 1'b0, 1'b0);
        send_stuff_violation();
        idle_bits(14);
        if (err_pulses != 1 || valid_cnt != frames_sent) begin
            seq_errs++;
            $display("stuff violation did not give one stuff error without a frame");
        end
        run_frame(random_frame(), 1'b1, 1'b0);
        run_frame(random_frame(), 1'b0, 1'b1);
        run_frame(random_frame(), 1'b0, 1'b0);
        run_frame(random_frame(), 1'b0, 1'b0);
        $display("frames %0d, sequence errors %0d, frame mismatches %0d, assertion failures %0d",
                 valid_cnt, seq_errs, frame_errs, can_rx_top_i.can_rx_assert_i.fail_cnt);
        if (seq_errs + frame_errs + can_rx_top_i.can_rx_assert_i.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
logic/can_bus_pkg.sv
logic/can_frame_pkg.sv
logic/can_bit_timing.sv
logic/can_destuff.sv
logic/can_crc15.sv
logic/can_rx_fsm.sv
logic/can_field_capture.sv
logic/can_rx_top.sv
verification/can_rx_assert.sv
verification/tb_can_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_can_rx with Verilator, result taken from the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_can_rx -o tb_can_rx
./obj_dir/tb_can_rx +verilator+error+limit+1000 | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failure"
